// File: src/tlk_tx_pkg.sv
`default_nettype none

package tlk_tx_pkg;

    //////////////////////////////
    // widths and depths
    //////////////////////////////

    localparam int DMA_WIDTH     = 64;
    localparam int TXD_WIDTH     = 16;
    localparam int WORDS_PER_DMA = DMA_WIDTH / TXD_WIDTH;
    localparam int FIFO_DEPTH    = 256;
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    // 16-bit words, up to FIFO_DEPTH * WORDS_PER_DMA
    localparam int FIFO_WORDS_W  = 11;

    //////////////////////////////
    // 8b/10b control bytes
    //////////////////////////////

    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    localparam logic [7:0] K28_2 = 8'h5C;
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K29_7 = 8'hFD;
    localparam logic [7:0] K30_7 = 8'hFE;

    // comma, only the low byte is a k-char
    localparam logic [TXD_WIDTH-1:0] SYNC_WORD = {D5_6, K28_5};
    localparam logic [TXD_WIDTH-1:0] SOF_WORD  = {K28_2, K27_7};
    localparam logic [TXD_WIDTH-1:0] EOF_WORD  = {K29_7, K30_7};

    //////////////////////////////
    // frame contents
    //////////////////////////////

    localparam logic [TXD_WIDTH-1:0] HEAD_0 = 16'hEB90;
    localparam logic [TXD_WIDTH-1:0] HEAD_1 = 16'hE116;
    localparam logic [7:0] TX_IND   = 8'h81;
    localparam logic [7:0] FILE_END = 8'h01;

    // comma runs and test ramp
    localparam int SYNC_LEN   = 6;
    localparam int GAP_LEN    = 256;
    localparam int LINK_CNT_W = $clog2(GAP_LEN);
    localparam int RAMP_LEN   = 256;
    localparam int RAMP_CNT_W = $clog2(RAMP_LEN);

    //////////////////////////////
    // modes and states
    //////////////////////////////

    typedef enum logic [1:0] {
        MODE_NORM  = 2'd0,
        MODE_KCODE = 2'd1,
        MODE_TEST  = 2'd2
    } tx_mode_e;

    typedef enum logic [3:0] {
        TX_IDLE      = 4'd0,
        TX_SYNC      = 4'd1,
        TX_SOF       = 4'd2,
        TX_HEAD0     = 4'd3,
        TX_HEAD1     = 4'd4,
        TX_FILE_SIGN = 4'd5,
        TX_FRAME_NUM = 4'd6,
        TX_LEN       = 4'd7,
        TX_DATA      = 4'd8,
        TX_CSUM      = 4'd9,
        TX_EOF       = 4'd10,
        TX_GAP       = 4'd11
    } tx_state_e;

    typedef enum logic [1:0] {
        PAT_COMMA1 = 2'd0,
        PAT_COMMA2 = 2'd1,
        PAT_SOF    = 2'd2,
        PAT_DATA   = 2'd3
    } pat_state_e;

endpackage

`default_nettype wire

// File: src/tx_fifo_64to16.sv
`default_nettype none

module tx_fifo_64to16 (
    input  logic                                clk,
    input  logic                                i_soft_reset,
    input  logic                                i_wr_valid,
    input  logic [tlk_tx_pkg::DMA_WIDTH-1:0]    i_wr_data,
    input  logic                                i_rd,
    output logic                                o_wr_ready,
    output logic [tlk_tx_pkg::TXD_WIDTH-1:0]    o_rd_data,
    output logic [tlk_tx_pkg::FIFO_WORDS_W-1:0] o_word_count
);
    import tlk_tx_pkg::*;

    logic [DMA_WIDTH-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   entry_cnt;
    logic [1:0]            lane;
    logic [DMA_WIDTH-1:0]  rd_entry;
    logic                  wr_en;
    logic                  last_lane;
    logic                  pop;

    // msb of the entry count only set at FIFO_DEPTH
    assign o_wr_ready = !entry_cnt[FIFO_PTR_W];
    assign wr_en      = i_wr_valid && o_wr_ready;
    assign last_lane  = (lane == 2'(WORDS_PER_DMA - 1));
    assign pop        = i_rd && last_lane;

    // first-word-fall-through with the low quarter first
    assign rd_entry  = mem[rd_ptr];
    assign o_rd_data = rd_entry[lane*TXD_WIDTH +: TXD_WIDTH];

    // quarters already handed out are no longer held
    assign o_word_count = {entry_cnt, 2'b00} - FIFO_WORDS_W'(lane);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            lane      <= '0;
            entry_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd) begin
                if (last_lane) begin
                    lane   <= '0;
                    rd_ptr <= rd_ptr + 1'b1;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
            case ({wr_en, pop})
                2'b10:   entry_cnt <= entry_cnt + 1'b1;
                2'b01:   entry_cnt <= entry_cnt - 1'b1;
                default: entry_cnt <= entry_cnt;
            endcase
        end
    end

    // framer waits for a whole frame and never reads past the data held
    a_no_underflow: assert property (
        @(posedge clk) disable iff (i_soft_reset)
        i_rd |-> (o_word_count != '0)
    );

    // never more words held than the entries can store
    a_no_overflow: assert property (
        @(posedge clk) disable iff (i_soft_reset)
        o_word_count <= FIFO_WORDS_W'(FIFO_DEPTH * WORDS_PER_DMA)
    );

endmodule

`default_nettype wire

// File: src/tx_frame_fsm.sv
`default_nettype none

module tx_frame_fsm (
    input  logic                                clk,
    input  logic                                i_soft_reset,
    input  logic                                i_start_norm,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0]    i_packet_body,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0]    i_packet_tail,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0]    i_body_num,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0]    i_fifo_data,
    input  logic [tlk_tx_pkg::FIFO_WORDS_W-1:0] i_fifo_words,
    output logic                                o_fifo_rd,
    output logic [tlk_tx_pkg::TXD_WIDTH-1:0]    o_char,
    output logic                                o_tk_msb,
    output logic                                o_tk_lsb,
    output logic                                o_tx_interrupt
);
    import tlk_tx_pkg::*;

    tx_state_e             state;
    tx_state_e             state_next;
    logic                  cfg_pending;
    logic                  last_frame;
    logic [LINK_CNT_W-1:0] link_cnt;
    logic [TXD_WIDTH-1:0]  frame_cnt;
    logic [TXD_WIDTH-1:0]  valid_len;
    logic [TXD_WIDTH-1:0]  data_cnt;
    logic [TXD_WIDTH-1:0]  checksum;
    logic [TXD_WIDTH-1:0]  next_len;
    logic                  frame_ready;
    logic                  sync_done;
    logic                  gap_done;
    logic                  data_done;

    // length of the frame about to start, lengths are in bytes
    assign next_len    = (frame_cnt == i_body_num) ? i_packet_tail : i_packet_body;
    assign frame_ready = cfg_pending &&
                         (TXD_WIDTH'(i_fifo_words) >= {1'b0, next_len[TXD_WIDTH-1:1]});

    assign sync_done = (link_cnt == LINK_CNT_W'(SYNC_LEN - 1));
    assign gap_done  = (link_cnt == LINK_CNT_W'(GAP_LEN - 1));
    assign data_done = (data_cnt == {1'b0, valid_len[TXD_WIDTH-1:1]} - TXD_WIDTH'(1));

    always_comb begin
        state_next = state;
        case (state)
            TX_IDLE: begin
                // sync commas only ahead of the first frame
                if (frame_ready) begin
                    state_next = (frame_cnt == '0) ? TX_SYNC : TX_SOF;
                end
            end
            TX_SYNC:      if (sync_done) state_next = TX_SOF;
            TX_SOF:       state_next = TX_HEAD0;
            TX_HEAD0:     state_next = TX_HEAD1;
            TX_HEAD1:     state_next = TX_FILE_SIGN;
            TX_FILE_SIGN: state_next = TX_FRAME_NUM;
            TX_FRAME_NUM: state_next = TX_LEN;
            TX_LEN:       state_next = (valid_len == '0) ? TX_CSUM : TX_DATA;
            TX_DATA:      if (data_done) state_next = TX_CSUM;
            TX_CSUM:      state_next = TX_EOF;
            TX_EOF:       state_next = TX_GAP;
            TX_GAP:       if (gap_done) state_next = TX_IDLE;
            default:      state_next = TX_IDLE;
        endcase
    end

    //////////////////////////////
    // state and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state          <= TX_IDLE;
            cfg_pending    <= 1'b0;
            last_frame     <= 1'b0;
            link_cnt       <= '0;
            frame_cnt      <= '0;
            data_cnt       <= '0;
            o_tx_interrupt <= 1'b0;
        end else begin
            state <= state_next;
            if (i_start_norm) begin
                cfg_pending <= 1'b1;
            end else if (state == TX_EOF && last_frame) begin
                cfg_pending <= 1'b0;
            end
            if (state == TX_SYNC || state == TX_GAP) begin
                link_cnt <= link_cnt + 1'b1;
            end else begin
                link_cnt <= '0;
            end
            if (state == TX_SOF) begin
                last_frame <= (frame_cnt == i_body_num);
            end
            if (state == TX_EOF) begin
                frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;
            end
            if (state == TX_DATA) begin
                data_cnt <= data_cnt + 1'b1;
            end else begin
                data_cnt <= '0;
            end
            o_tx_interrupt <= (state == TX_GAP) && gap_done && last_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_SOF) begin
            valid_len <= next_len;
        end
    end

    // sum of everything between header and checksum
    always_ff @(posedge clk) begin
        case (state)
            TX_SOF:                                     checksum <= '0;
            TX_FILE_SIGN, TX_FRAME_NUM, TX_LEN, TX_DATA: checksum <= checksum + o_char;
            default:                                    checksum <= checksum;
        endcase
    end

    //////////////////////////////
    // character per state
    //////////////////////////////

    assign o_fifo_rd = (state == TX_DATA);

    always_comb begin
        o_char   = '0;
        o_tk_msb = 1'b0;
        o_tk_lsb = 1'b0;
        case (state)
            TX_SYNC, TX_GAP: begin
                o_char   = SYNC_WORD;
                o_tk_lsb = 1'b1;
            end
            TX_SOF: begin
                o_char   = SOF_WORD;
                o_tk_msb = 1'b1;
                o_tk_lsb = 1'b1;
            end
            TX_HEAD0:     o_char = HEAD_0;
            TX_HEAD1:     o_char = HEAD_1;
            TX_FILE_SIGN: o_char = {TX_IND, last_frame ? FILE_END : 8'h00};
            TX_FRAME_NUM: o_char = frame_cnt;
            TX_LEN:       o_char = valid_len;
            TX_DATA:      o_char = i_fifo_data;
            TX_CSUM:      o_char = checksum;
            TX_EOF: begin
                o_char   = EOF_WORD;
                o_tk_msb = 1'b1;
                o_tk_lsb = 1'b1;
            end
            default:      o_char = '0;
        endcase
    end

    // data is read as 16-bit words, so odd lengths cannot be framed
    a_even_len: assert property (
        @(posedge clk) disable iff (i_soft_reset)
        (state == TX_SOF) |=> !valid_len[0]
    );

endmodule

`default_nettype wire

// File: src/tx_test_pattern.sv
`default_nettype none

module tx_test_pattern (
    input  logic                             clk,
    input  logic                             i_soft_reset,
    input  logic                             i_run,
    output logic [tlk_tx_pkg::TXD_WIDTH-1:0] o_char,
    output logic                             o_tk_msb,
    output logic                             o_tk_lsb
);
    import tlk_tx_pkg::*;

    pat_state_e            pat_state;
    logic [RAMP_CNT_W-1:0] ramp_cnt;

    always_ff @(posedge clk) begin
        if (i_soft_reset || !i_run) begin
            pat_state <= PAT_COMMA1;
            ramp_cnt  <= '0;
        end else begin
            case (pat_state)
                PAT_COMMA1: pat_state <= PAT_COMMA2;
                PAT_COMMA2: pat_state <= PAT_SOF;
                PAT_SOF:    pat_state <= PAT_DATA;
                PAT_DATA: begin
                    if (ramp_cnt == RAMP_CNT_W'(RAMP_LEN - 1)) begin
                        ramp_cnt  <= '0;
                        pat_state <= PAT_COMMA1;
                    end else begin
                        ramp_cnt <= ramp_cnt + 1'b1;
                    end
                end
                default:    pat_state <= PAT_COMMA1;
            endcase
        end
    end

    // ramp value in both bytes
    assign o_char   = (pat_state == PAT_DATA) ? {ramp_cnt, ramp_cnt} :
                      (pat_state == PAT_SOF)  ? SOF_WORD : SYNC_WORD;
    assign o_tk_msb = (pat_state == PAT_SOF);
    assign o_tk_lsb = (pat_state != PAT_DATA);

endmodule

`default_nettype wire

// File: src/tlk2711_tx.sv
`default_nettype none

module tlk2711_tx (
    input  logic                             clk,
    input  logic                             i_soft_reset,
    input  logic                             i_tx_start,
    input  tlk_tx_pkg::tx_mode_e             i_tx_mode,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0] i_tx_packet_body,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0] i_tx_packet_tail,
    input  logic [tlk_tx_pkg::TXD_WIDTH-1:0] i_tx_body_num,
    input  logic                             i_dma_rd_valid,
    input  logic [tlk_tx_pkg::DMA_WIDTH-1:0] i_dma_rd_data,
    output logic                             o_dma_rd_ready,
    output logic                             o_tx_interrupt,
    output logic [tlk_tx_pkg::TXD_WIDTH-1:0] o_2711_txd,
    output logic                             o_2711_tkmsb,
    output logic                             o_2711_tklsb
);
    import tlk_tx_pkg::*;

    tx_mode_e              mode_q;
    logic                  start_norm;
    logic                  pat_run;
    logic                  fifo_rd;
    logic [TXD_WIDTH-1:0]  fifo_data;
    logic [FIFO_WORDS_W-1:0] fifo_words;
    logic [TXD_WIDTH-1:0]  frm_char;
    logic                  frm_tk_msb;
    logic                  frm_tk_lsb;
    logic [TXD_WIDTH-1:0]  pat_char;
    logic                  pat_tk_msb;
    logic                  pat_tk_lsb;
    logic [TXD_WIDTH-1:0]  mux_char;
    logic                  mux_tk_msb;
    logic                  mux_tk_lsb;

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            mode_q <= MODE_NORM;
        end else if (i_tx_start) begin
            mode_q <= i_tx_mode;
        end
    end

    assign start_norm = i_tx_start && (i_tx_mode == MODE_NORM);
    assign pat_run    = (mode_q == MODE_TEST);

    tx_fifo_64to16 u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_valid   (i_dma_rd_valid),
        .i_wr_data    (i_dma_rd_data),
        .i_rd         (fifo_rd),
        .o_wr_ready   (o_dma_rd_ready),
        .o_rd_data    (fifo_data),
        .o_word_count (fifo_words)
    );

    tx_frame_fsm u_framer (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_start_norm   (start_norm),
        .i_packet_body  (i_tx_packet_body),
        .i_packet_tail  (i_tx_packet_tail),
        .i_body_num     (i_tx_body_num),
        .i_fifo_data    (fifo_data),
        .i_fifo_words   (fifo_words),
        .o_fifo_rd      (fifo_rd),
        .o_char         (frm_char),
        .o_tk_msb       (frm_tk_msb),
        .o_tk_lsb       (frm_tk_lsb),
        .o_tx_interrupt (o_tx_interrupt)
    );

    tx_test_pattern u_pattern (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_run        (pat_run),
        .o_char       (pat_char),
        .o_tk_msb     (pat_tk_msb),
        .o_tk_lsb     (pat_tk_lsb)
    );

    //////////////////////////////
    // character select per mode
    //////////////////////////////

    always_comb begin
        case (mode_q)
            MODE_NORM: begin
                mux_char   = frm_char;
                mux_tk_msb = frm_tk_msb;
                mux_tk_lsb = frm_tk_lsb;
            end
            MODE_KCODE: begin
                mux_char   = SOF_WORD;
                mux_tk_msb = 1'b1;
                mux_tk_lsb = 1'b1;
            end
            MODE_TEST: begin
                mux_char   = pat_char;
                mux_tk_msb = pat_tk_msb;
                mux_tk_lsb = pat_tk_lsb;
            end
            default: begin
                mux_char   = '0;
                mux_tk_msb = 1'b0;
                mux_tk_lsb = 1'b0;
            end
        endcase
    end

    // one register stage in front of the chip pins
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd   <= '0;
            o_2711_tkmsb <= 1'b0;
            o_2711_tklsb <= 1'b0;
        end else begin
            o_2711_txd   <= mux_char;
            o_2711_tkmsb <= mux_tk_msb;
            o_2711_tklsb <= mux_tk_lsb;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_tlk2711_tx.sv
`default_nettype none

module tb_tlk2711_tx;
    import tlk_tx_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DLY   = 10;
    localparam int SOF_TIMEOUT = 1000;
    localparam int IRQ_TIMEOUT = 600;

    logic                 clk = 1'b0;
    logic                 i_soft_reset;
    logic                 i_tx_start;
    tx_mode_e             i_tx_mode;
    logic [TXD_WIDTH-1:0] i_tx_packet_body;
    logic [TXD_WIDTH-1:0] i_tx_packet_tail;
    logic [TXD_WIDTH-1:0] i_tx_body_num;
    logic                 i_dma_rd_valid;
    logic [DMA_WIDTH-1:0] i_dma_rd_data;
    logic                 o_dma_rd_ready;
    logic                 o_tx_interrupt;
    logic [TXD_WIDTH-1:0] o_2711_txd;
    logic                 o_2711_tkmsb;
    logic                 o_2711_tklsb;

    int seed      = 18;
    int irq_count = 0;
    int irq_base  = 0;

    // 16-bit words in link order with the low quarter of each DMA word first
    logic [TXD_WIDTH-1:0] exp_words [$];

    tlk2711_tx dut0 (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_start       (i_tx_start),
        .i_tx_mode        (i_tx_mode),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_dma_rd_valid   (i_dma_rd_valid),
        .i_dma_rd_data    (i_dma_rd_data),
        .o_dma_rd_ready   (o_dma_rd_ready),
        .o_tx_interrupt   (o_tx_interrupt),
        .o_2711_txd       (o_2711_txd),
        .o_2711_tkmsb     (o_2711_tkmsb),
        .o_2711_tklsb     (o_2711_tklsb)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // cycles with the interrupt high
    always @(posedge clk) begin
        if (o_tx_interrupt) begin
            irq_count <= irq_count + 1;
        end
    end

    //////////////////////////////
    // helpers and compare tasks
    //////////////////////////////

    // outputs are stable and inputs are driven here
    task automatic tick();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(input string what);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, what));
    endtask

    task automatic timeout_error(input string what);
        abort_run($sformatf("Timed out at %0t while waiting for %s", $time, what));
    endtask

    task automatic check_word(input logic [TXD_WIDTH-1:0] got, input logic [TXD_WIDTH-1:0] exp,
                              input string what);
        if (got !== exp) begin
            value_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flags(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s: K-flags %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    // expected chip output per mode with the ramp value for test mode
    task automatic check_mode(input tx_mode_e mode, input logic [7:0] ramp, input string what);
        logic [TXD_WIDTH-1:0] exp_char;
        logic [1:0]           exp_flags;
        case (mode)
            MODE_KCODE: begin
                exp_char  = SOF_WORD;
                exp_flags = 2'b11;
            end
            MODE_TEST: begin
                exp_char  = {ramp, ramp};
                exp_flags = 2'b00;
            end
            default: begin
                exp_char  = '0;
                exp_flags = 2'b00;
            end
        endcase
        if (o_2711_txd !== exp_char || {o_2711_tkmsb, o_2711_tklsb} !== exp_flags) begin
            value_error($sformatf("%s in %s: got %h/%b, expected %h/%b", what, mode.name(),
                                  o_2711_txd, {o_2711_tkmsb, o_2711_tklsb}, exp_char, exp_flags));
        end
    endtask

    //////////////////////////////
    // drivers and frame parser
    //////////////////////////////

    task automatic push_dma_word();
        logic [DMA_WIDTH-1:0] word;
        int                   waited;
        int                   q;
        word           = {$random(seed), $random(seed)};
        waited         = 0;
        i_dma_rd_valid = 1'b1;
        i_dma_rd_data  = word;
        while (!o_dma_rd_ready) begin
            if (waited == SOF_TIMEOUT) begin
                timeout_error("DMA ready");
            end
            tick();
            waited++;
        end
        // word is taken on this edge
        tick();
        i_dma_rd_valid = 1'b0;
        for (q = 0; q < WORDS_PER_DMA; q++) begin
            exp_words.push_back(word[q*TXD_WIDTH +: TXD_WIDTH]);
        end
    endtask

    // second tick lets the output register follow the new mode
    task automatic start_pulse(input tx_mode_e mode);
        i_tx_mode  = mode;
        i_tx_start = 1'b1;
        tick();
        i_tx_start = 1'b0;
        tick();
    endtask

    task automatic wait_for_sof(input string what);
        int waited;
        waited = 0;
        while (!(o_2711_txd == SOF_WORD && o_2711_tkmsb && o_2711_tklsb)) begin
            if (waited == SOF_TIMEOUT) begin
                timeout_error(what);
            end
            tick();
            waited++;
        end
    endtask

    task automatic check_frame(input logic [TXD_WIDTH-1:0] frame_num,
                               input logic [TXD_WIDTH-1:0] len, input logic last);
        logic [TXD_WIDTH-1:0] words [$];
        logic [TXD_WIDTH-1:0] sign;
        logic [TXD_WIDTH-1:0] sum;
        logic [TXD_WIDTH-1:0] exp_data;
        int                   half;
        int                   n;
        int                   i;
        half = int'(len) / 2;
        n    = 0;
        wait_for_sof("start-of-frame");
        tick();
        while (!(o_2711_txd == EOF_WORD && o_2711_tkmsb && o_2711_tklsb)) begin
            if (n == half + 10) begin
                timeout_error("end-of-frame");
            end
            check_flags({o_2711_tkmsb, o_2711_tklsb}, 2'b00, "character inside frame");
            words.push_back(o_2711_txd);
            tick();
            n++;
        end
        check_word(16'(words.size()), 16'(half + 6), "characters between SOF and EOF");
        sign = {TX_IND, last ? FILE_END : 8'h00};
        check_word(words[0], HEAD_0, "header word 0");
        check_word(words[1], HEAD_1, "header word 1");
        check_word(words[2], sign, "file sign");
        check_word(words[3], frame_num, "frame number");
        check_word(words[4], len, "valid length");
        sum = sign + frame_num + len;
        for (i = 0; i < half; i++) begin
            exp_data = exp_words.pop_front();
            sum      = sum + exp_data;
            check_word(words[5 + i], exp_data,
                       $sformatf("data word %0d of frame %0d", i, frame_num));
        end
        check_word(words[5 + half], sum, "checksum");
    endtask

    task automatic check_interrupt_pulse();
        int waited;
        waited = 0;
        while (irq_count == irq_base) begin
            if (waited == IRQ_TIMEOUT) begin
                timeout_error("transfer interrupt");
            end
            tick();
            waited++;
        end
        repeat (4) tick();
        check_word(16'(irq_count - irq_base), 16'd1, "interrupt cycles after transfer");
        irq_base = irq_count;
    endtask

    task automatic run_transfer(input logic [TXD_WIDTH-1:0] body_num,
                                input logic [TXD_WIDTH-1:0] body,
                                input logic [TXD_WIDTH-1:0] tail, input logic push);
        logic [TXD_WIDTH-1:0] len;
        int                   total;
        int                   d;
        int                   f;
        i_tx_body_num    = body_num;
        i_tx_packet_body = body;
        i_tx_packet_tail = tail;
        if (push) begin
            total = int'(body_num) * int'(body) / 2 + int'(tail) / 2;
            for (d = 0; d < total / WORDS_PER_DMA; d++) begin
                push_dma_word();
            end
        end
        irq_base = irq_count;
        start_pulse(MODE_NORM);
        for (f = 0; f <= int'(body_num); f++) begin
            len = (f == int'(body_num)) ? tail : body;
            check_frame(16'(f), len, f == int'(body_num));
            if (f != int'(body_num)) begin
                check_word(16'(irq_count - irq_base), 16'd0, "interrupt before last frame");
            end
        end
        check_interrupt_pulse();
        check_word(16'(exp_words.size()), 16'd0, "DMA words left unsent");
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_single_frame();
        run_transfer(16'd0, 16'd16, 16'd16, 1'b1);
    endtask

    task automatic test_multi_frame();
        run_transfer(16'd2, 16'd24, 16'd8, 1'b1);
    endtask

    task automatic test_back_pressure();
        int count;
        count = 0;
        while (o_dma_rd_ready) begin
            if (count == FIFO_DEPTH + 4) begin
                timeout_error("DMA ready to drop on a full FIFO");
            end
            push_dma_word();
            count++;
        end
        check_word(16'(count), 16'(FIFO_DEPTH), "DMA words accepted before full");
        // a single frame as long as the whole FIFO drains it
        run_transfer(16'd0, 16'(FIFO_DEPTH * WORDS_PER_DMA * 2),
                     16'(FIFO_DEPTH * WORDS_PER_DMA * 2), 1'b0);
        check_bit(o_dma_rd_ready, 1'b1, "DMA ready after drain");
    endtask

    task automatic test_kcode();
        start_pulse(MODE_KCODE);
        repeat (20) begin
            check_mode(MODE_KCODE, 8'h00, "K-code output");
            tick();
        end
    endtask

    task automatic test_pattern();
        int i;
        start_pulse(MODE_TEST);
        wait_for_sof("test pattern start-of-frame");
        for (i = 0; i < RAMP_LEN; i++) begin
            tick();
            check_mode(MODE_TEST, 8'(i), $sformatf("ramp word %0d", i));
        end
        repeat (2) begin
            tick();
            check_word(o_2711_txd, SYNC_WORD, "comma after ramp");
            check_flags({o_2711_tkmsb, o_2711_tklsb}, 2'b01, "comma after ramp");
        end
        tick();
        check_word(o_2711_txd, SOF_WORD, "start-of-frame after commas");
        check_flags({o_2711_tkmsb, o_2711_tklsb}, 2'b11, "start-of-frame after commas");
    endtask

    task automatic test_reset_mid_frame();
        i_tx_body_num    = 16'd0;
        i_tx_packet_body = 16'd16;
        i_tx_packet_tail = 16'd16;
        repeat (2) push_dma_word();
        start_pulse(MODE_NORM);
        wait_for_sof("frame before reset");
        // SOF and five header characters come before the data
        repeat (7) tick();
        i_soft_reset = 1'b1;
        repeat (2) tick();
        check_mode(MODE_NORM, 8'h00, "outputs during reset");
        check_bit(o_tx_interrupt, 1'b0, "interrupt during reset");
        i_soft_reset = 1'b0;
        exp_words.delete();
        irq_base = irq_count;
        repeat (10) begin
            tick();
            check_mode(MODE_NORM, 8'h00, "idle after reset");
        end
        check_word(16'(irq_count - irq_base), 16'd0, "interrupt after reset");
        check_bit(o_dma_rd_ready, 1'b1, "DMA ready after reset");
        run_transfer(16'd0, 16'd16, 16'd16, 1'b1);
    endtask

    initial begin
        i_soft_reset     = 1'b1;
        i_tx_start       = 1'b0;
        i_tx_mode        = MODE_NORM;
        i_tx_packet_body = '0;
        i_tx_packet_tail = '0;
        i_tx_body_num    = '0;
        i_dma_rd_valid   = 1'b0;
        i_dma_rd_data    = '0;
        repeat (2) tick();
        i_soft_reset = 1'b0;
        tick();
        check_mode(MODE_NORM, 8'h00, "outputs after reset");
        check_bit(o_tx_interrupt, 1'b0, "interrupt after reset");
        check_bit(o_dma_rd_ready, 1'b1, "DMA ready after reset");

        test_single_frame();
        test_multi_frame();
        test_back_pressure();
        test_kcode();
        test_pattern();
        test_reset_mid_frame();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlk2711_tx.f
src/tlk_tx_pkg.sv
src/tx_fifo_64to16.sv
src/tx_frame_fsm.sv
src/tx_test_pattern.sv
src/tlk2711_tx.sv
verif/tb_tlk2711_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tlk2711_tx.f \
    --top-module tb_tlk2711_tx \
    --Mdir obj_dir \
    -o sim_tlk2711_tx
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tlk2711_tx 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
